// File: source/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth        = 32;
    localparam int AddrWidthDefault = 9;
    localparam int RegCountDefault  = 16;

    // Instruction layout is opcode | ra | rb | C
    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 27;
    localparam int RaMsb     = 26;
    localparam int RaLsb     = 23;
    localparam int RbMsb     = 22;
    localparam int RbLsb     = 19;
    localparam int ConstMsb  = 18;
    localparam int ConstLsb  = 0;
    localparam int RegFieldWidth = RaMsb - RaLsb + 1;
    localparam int ConstWidth    = ConstMsb - ConstLsb + 1;

    typedef enum logic [4:0] {
        opAddi = 5'b00011,
        opAndi = 5'b01011,
        opOri  = 5'b01010,
        opOut  = 5'b10110,
        opHalt = 5'b11011
    } opcodeType;

    typedef enum logic [2:0] {
        stepIdle,
        stepT0,
        stepT1,
        stepT2,
        stepT3,
        stepT4,
        stepT5,
        stepHalted
    } stepType;

    // Who owns the bus this cycle
    typedef enum logic [2:0] {
        srcNone,
        srcReg,
        srcPc,
        srcMdr,
        srcZ,
        srcConst
    } busSourceType;

endpackage

// File: source/generalRegister.sv
`timescale 1ns/1ps

module generalRegister (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         load,
    input  logic [cpuPkg::DataWidth-1:0] bus,
    output logic [cpuPkg::DataWidth-1:0] value
);

    always_ff @(posedge Clock) begin
        if (rst) begin
            value <= '0;
        end else if (load) begin
            value <= bus; // Capture from the shared bus
        end
    end

endmodule

// File: source/registerDecoder.sv
`timescale 1ns/1ps

module registerDecoder #(
    parameter int RegCount = cpuPkg::RegCountDefault
) (
    input  logic [cpuPkg::DataWidth-1:0] instruction,
    input  logic                         grA,
    input  logic                         grB,
    input  logic                         regIn,
    input  logic                         regOut,
    output logic [RegCount-1:0]          regLoadVector,
    output logic [RegCount-1:0]          regDriveVector
);

    import cpuPkg::*;

    logic [RegFieldWidth-1:0] regIndex;
    logic                     anySelect;

    assign anySelect = grA | grB;
    assign regIndex  = grA ? instruction[RaMsb:RaLsb] : instruction[RbMsb:RbLsb]; // ra wins

    // One-hot decode where an out of range index hits nothing
    always_comb begin
        for (int i = 0; i < RegCount; i++) begin
            regLoadVector[i]  = anySelect && regIn && (int'(regIndex) == i);
            regDriveVector[i] = anySelect && regOut && (int'(regIndex) == i);
        end
    end

endmodule

// File: source/busMux.sv
`timescale 1ns/1ps

module busMux #(
    parameter int AddrWidth = cpuPkg::AddrWidthDefault,
    parameter int RegCount  = cpuPkg::RegCountDefault
) (
    input  cpuPkg::busSourceType                        busSource,
    input  logic [RegCount-1:0]                         regDriveVector,
    input  logic [RegCount-1:0][cpuPkg::DataWidth-1:0]  registerValues,
    input  logic [AddrWidth-1:0]                        pcValue,
    input  logic [cpuPkg::DataWidth-1:0]                mdrValue,
    input  logic [cpuPkg::DataWidth-1:0]                zValue,
    input  logic [cpuPkg::DataWidth-1:0]                instruction,
    output logic [cpuPkg::DataWidth-1:0]                bus
);

    import cpuPkg::*;

    logic [DataWidth-1:0] regSelected;
    logic [DataWidth-1:0] constValue;

    // Decoder guarantees at most one bit set
    always_comb begin
        regSelected = '0;
        for (int i = 0; i < RegCount; i++) begin
            if (regDriveVector[i]) begin
                regSelected = regSelected | registerValues[i];
            end
        end
    end

    assign constValue = {{(DataWidth - ConstWidth){instruction[ConstMsb]}},
                         instruction[ConstMsb:ConstLsb]}; // Sign-extended C

    always_comb begin
        case (busSource)
            srcReg:   bus = regSelected;
            srcPc:    bus = DataWidth'(pcValue); // Zero-extended word address
            srcMdr:   bus = mdrValue;
            srcZ:     bus = zValue;
            srcConst: bus = constValue;
            default:  bus = '0; // Idle bus reads as zero
        endcase
    end

endmodule

// File: source/arithmeticUnit.sv
`timescale 1ns/1ps

module arithmeticUnit (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         yLoad,
    input  logic                         zLoad,
    input  cpuPkg::opcodeType            aluOp,
    input  logic [cpuPkg::DataWidth-1:0] bus,
    output logic [cpuPkg::DataWidth-1:0] zValue
);

    import cpuPkg::*;

    logic [DataWidth-1:0] yValue;
    logic [DataWidth-1:0] aluResult;

    always_comb begin
        case (aluOp)
            opAndi:  aluResult = yValue & bus;
            opOri:   aluResult = yValue | bus;
            default: aluResult = yValue + bus; // addi and anything unused
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            yValue <= '0;
            zValue <= '0;
        end else begin
            if (yLoad) yValue <= bus; // First operand, register rb
            if (zLoad) zValue <= aluResult;
        end
    end

endmodule

// File: source/specialRegisters.sv
`timescale 1ns/1ps

module specialRegisters #(
    parameter int AddrWidth = cpuPkg::AddrWidthDefault
) (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         marLoad,
    input  logic                         mdrLoad,
    input  logic                         irLoad,
    input  logic                         pcIncrement,
    input  logic                         outLoad,
    input  logic [cpuPkg::DataWidth-1:0] bus,
    input  logic [cpuPkg::DataWidth-1:0] cpuReadData,
    output logic [AddrWidth-1:0]         pcValue,
    output logic [AddrWidth-1:0]         marValue,
    output logic [cpuPkg::DataWidth-1:0] mdrValue,
    output logic [cpuPkg::DataWidth-1:0] instruction,
    output logic [cpuPkg::DataWidth-1:0] outPort,
    output logic                         outValid
);

    // Program counter and output port
    always_ff @(posedge Clock) begin
        if (rst) begin
            pcValue     <= '0;
            instruction <= '0;
            outPort     <= '0;
            outValid    <= 1'b0;
        end else begin
            if (pcIncrement) begin
                pcValue <= pcValue + 1'b1; // Wraps at the memory size
            end
            if (irLoad) begin
                instruction <= bus;
            end
            if (outLoad) begin
                outPort <= bus;
            end
            outValid <= outLoad; // Strobe follows the load by one cycle
        end
    end

    // Memory interface registers
    always_ff @(posedge Clock) begin
        if (marLoad) begin
            marValue <= bus[AddrWidth-1:0];
        end
        if (mdrLoad) begin
            mdrValue <= cpuReadData; // Straight from memory, not the bus
        end
    end

endmodule

// File: source/programMemory.sv
`timescale 1ns/1ps

module programMemory #(
    parameter int AddrWidth = cpuPkg::AddrWidthDefault
) (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [AddrWidth-1:0]         wbAdr,
    input  logic [cpuPkg::DataWidth-1:0] wbWriteData,
    output logic [cpuPkg::DataWidth-1:0] wbReadData,
    output logic                         wbAck,
    input  logic [AddrWidth-1:0]         marValue,
    output logic [cpuPkg::DataWidth-1:0] cpuReadData
);

    import cpuPkg::*;

    localparam int Depth = 2 ** AddrWidth;

    logic [DataWidth-1:0] memory [Depth];
    logic                 wbAccept;

    initial begin
        for (int i = 0; i < Depth; i++) begin
            memory[i] = '0;
        end
    end

    assign wbAccept = wbCyc && wbStb && !wbAck; // Blocks a second ack while held

    always_ff @(posedge Clock) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbAccept;
        end
    end

    always_ff @(posedge Clock) begin
        if (wbAccept && wbWe) begin
            memory[wbAdr] <= wbWriteData;
        end
        wbReadData <= memory[wbAdr]; // Valid alongside ack
    end

    assign cpuReadData = memory[marValue]; // Asynchronous fetch port

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         run,
    input  logic [cpuPkg::DataWidth-1:0] instruction,
    output logic                         grA,
    output logic                         grB,
    output logic                         regIn,
    output logic                         regOut,
    output cpuPkg::busSourceType         busSource,
    output logic                         marLoad,
    output logic                         mdrLoad,
    output logic                         irLoad,
    output logic                         pcIncrement,
    output logic                         yLoad,
    output logic                         zLoad,
    output logic                         outLoad,
    output cpuPkg::opcodeType            aluOp,
    output logic                         halted
);

    import cpuPkg::*;

    stepType   state;
    stepType   nextState;
    opcodeType opcode;
    logic      isAluOp;

    assign opcode  = opcodeType'(instruction[OpcodeMsb:OpcodeLsb]);
    assign isAluOp = (opcode == opAddi) || (opcode == opAndi) || (opcode == opOri);
    assign aluOp   = isAluOp ? opcode : opAddi;
    assign halted  = (state == stepHalted);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= stepIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            stepIdle:   nextState = run ? stepT0 : stepIdle;
            stepT0:     nextState = stepT1;
            stepT1:     nextState = stepT2;
            stepT2:     nextState = stepT3;
            stepT3:     nextState = (opcode == opHalt) ? stepHalted : stepT4;
            stepT4:     nextState = stepT5;
            stepT5:     nextState = run ? stepT0 : stepIdle; // Run sampled per instruction
            stepHalted: nextState = stepHalted; // Only reset leaves
            default:    nextState = stepIdle;
        endcase
    end

    always_comb begin
        grA         = 1'b0;
        grB         = 1'b0;
        regIn       = 1'b0;
        regOut      = 1'b0;
        busSource   = srcNone;
        marLoad     = 1'b0;
        mdrLoad     = 1'b0;
        irLoad      = 1'b0;
        pcIncrement = 1'b0;
        yLoad       = 1'b0;
        zLoad       = 1'b0;
        outLoad     = 1'b0;
        case (state)
            stepT0: begin
                busSource = srcPc;
                marLoad   = 1'b1;
            end
            stepT1: begin
                mdrLoad     = 1'b1; // Fetch word at MAR
                pcIncrement = 1'b1;
            end
            stepT2: begin
                busSource = srcMdr;
                irLoad    = 1'b1;
            end
            stepT3: begin
                if (isAluOp) begin
                    grB       = 1'b1; // rb into Y
                    regOut    = 1'b1;
                    busSource = srcReg;
                    yLoad     = 1'b1;
                end else if (opcode == opOut) begin
                    grA       = 1'b1;
                    regOut    = 1'b1;
                    busSource = srcReg;
                    outLoad   = 1'b1;
                end
            end
            stepT4: begin
                if (isAluOp) begin
                    busSource = srcConst;
                    zLoad     = 1'b1;
                end
            end
            stepT5: begin
                if (isAluOp) begin
                    busSource = srcZ; // Result back to ra
                    grA       = 1'b1;
                    regIn     = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter int AddrWidth = cpuPkg::AddrWidthDefault,
    parameter int RegCount  = cpuPkg::RegCountDefault
) (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic                         run,
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [AddrWidth-1:0]         wbAdr,
    input  logic [cpuPkg::DataWidth-1:0] wbWriteData,
    output logic [cpuPkg::DataWidth-1:0] wbReadData,
    output logic                         wbAck,
    output logic [cpuPkg::DataWidth-1:0] outPort,
    output logic                         outValid,
    output logic                         halted
);

    import cpuPkg::*;

    logic grA;
    logic grB;
    logic regIn;
    logic regOut;
    logic marLoad;
    logic mdrLoad;
    logic irLoad;
    logic pcIncrement;
    logic yLoad;
    logic zLoad;
    logic outLoad;
    busSourceType busSource;
    opcodeType    aluOp;

    logic [DataWidth-1:0] bus;
    logic [DataWidth-1:0] instruction;
    logic [DataWidth-1:0] mdrValue;
    logic [DataWidth-1:0] zValue;
    logic [DataWidth-1:0] cpuReadData;
    logic [AddrWidth-1:0] pcValue;
    logic [AddrWidth-1:0] marValue;
    logic [RegCount-1:0]  regLoadVector;
    logic [RegCount-1:0]  regDriveVector;
    logic [RegCount-1:0][DataWidth-1:0] registerValues;

    controlUnit controlUnit_i (
        .Clock(Clock), .rst(rst), .run(run), .instruction(instruction),
        .grA(grA), .grB(grB), .regIn(regIn), .regOut(regOut), .busSource(busSource),
        .marLoad(marLoad), .mdrLoad(mdrLoad), .irLoad(irLoad), .pcIncrement(pcIncrement),
        .yLoad(yLoad), .zLoad(zLoad), .outLoad(outLoad), .aluOp(aluOp), .halted(halted)
    );

    registerDecoder #(.RegCount(RegCount)) registerDecoder_i (
        .instruction(instruction), .grA(grA), .grB(grB), .regIn(regIn), .regOut(regOut),
        .regLoadVector(regLoadVector), .regDriveVector(regDriveVector)
    );

    // Register file with r0 as an ordinary register
    for (genvar i = 0; i < RegCount; i++) begin : regFile
        generalRegister generalRegister_i (
            .Clock(Clock), .rst(rst), .load(regLoadVector[i]), .bus(bus),
            .value(registerValues[i])
        );
    end

    busMux #(.AddrWidth(AddrWidth), .RegCount(RegCount)) busMux_i (
        .busSource(busSource), .regDriveVector(regDriveVector),
        .registerValues(registerValues), .pcValue(pcValue), .mdrValue(mdrValue),
        .zValue(zValue), .instruction(instruction), .bus(bus)
    );

    arithmeticUnit arithmeticUnit_i (
        .Clock(Clock), .rst(rst), .yLoad(yLoad), .zLoad(zLoad), .aluOp(aluOp),
        .bus(bus), .zValue(zValue)
    );

    specialRegisters #(.AddrWidth(AddrWidth)) specialRegisters_i (
        .Clock(Clock), .rst(rst), .marLoad(marLoad), .mdrLoad(mdrLoad), .irLoad(irLoad),
        .pcIncrement(pcIncrement), .outLoad(outLoad), .bus(bus), .cpuReadData(cpuReadData),
        .pcValue(pcValue), .marValue(marValue), .mdrValue(mdrValue),
        .instruction(instruction), .outPort(outPort), .outValid(outValid)
    );

    programMemory #(.AddrWidth(AddrWidth)) programMemory_i (
        .Clock(Clock), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbWriteData(wbWriteData), .wbReadData(wbReadData), .wbAck(wbAck),
        .marValue(marValue), .cpuReadData(cpuReadData)
    );

endmodule

// File: testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    import cpuPkg::*;

    localparam int AddrWidth  = AddrWidthDefault;
    localparam int RegCount   = RegCountDefault;
    localparam int AckTimeout = 10;
    localparam int RunTimeout = 2000;

    logic                 Clock;
    logic                 rst;
    logic                 run;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [AddrWidth-1:0] wbAdr;
    logic [DataWidth-1:0] wbWriteData;
    logic [DataWidth-1:0] wbReadData;
    logic                 wbAck;
    logic [DataWidth-1:0] outPort;
    logic                 outValid;
    logic                 halted;

    // Reference model state
    logic [DataWidth-1:0] modelRegs [RegCount];
    logic [DataWidth-1:0] memModel [2**AddrWidth];
    logic [DataWidth-1:0] progWords [64];
    logic [DataWidth-1:0] expectedOut [64];
    int                   expectedGap [64];
    int                   progLength;
    int                   expectedCount;
    int                   instrSinceOut;
    logic [DataWidth-1:0] readExpected;

    // Bookkeeping updated on the falling edge only
    int   outIndex;
    int   cycleCount;
    int   lastPulseCycle;
    int   pendingCycle;
    logic pulsePending;

    string currentTest;
    int    errorCount;
    int    testsRun;
    int    testsFailed;
    int    errorsAtStart;

    cpuTop #(.AddrWidth(AddrWidth), .RegCount(RegCount)) cpuTop_i (
        .Clock(Clock), .rst(rst), .run(run), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbWriteData(wbWriteData), .wbReadData(wbReadData), .wbAck(wbAck),
        .outPort(outPort), .outValid(outValid), .halted(halted)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    always @(negedge Clock) begin
        cycleCount++;
        if (rst) begin
            outIndex     = 0;
            pulsePending = 1'b0;
        end else begin
            if (pulsePending) begin // Pulse already checked at the last rising edge
                outIndex++;
                lastPulseCycle = pendingCycle;
                pulsePending   = 1'b0;
            end
            if (outValid) begin
                pulsePending = 1'b1;
                pendingCycle = cycleCount;
            end
        end
    end

    task automatic noteMismatch(input string what, input int expected, input int actual);
        $display("FAIL %s %s expected %h actual %h", currentTest, what, expected, actual);
        errorCount++;
    endtask

    task automatic noteProblem(input string text);
        $display("ERROR in %s: %s", currentTest, text);
        errorCount++;
    endtask

    outValueCheck: assert property (@(posedge Clock) disable iff (rst)
        outValid |-> outPort == expectedOut[outIndex])
        else noteMismatch("outPort", expectedOut[outIndex], outPort);

    outExtraCheck: assert property (@(posedge Clock) disable iff (rst)
        outValid |-> outIndex < expectedCount)
        else noteProblem("outValid pulse beyond the expected outputs");

    outGapCheck: assert property (@(posedge Clock) disable iff (rst)
        (outValid && expectedGap[outIndex] != 0) |->
            cycleCount - lastPulseCycle == expectedGap[outIndex])
        else noteMismatch("outValid gap", expectedGap[outIndex], cycleCount - lastPulseCycle);

    outCountCheck: assert property (@(posedge Clock) disable iff (rst)
        $rose(halted) |-> outIndex == expectedCount)
        else noteMismatch("output count", expectedCount, outIndex);

    runLowCheck: assert property (@(posedge Clock) disable iff (rst) !run |-> !outValid)
        else noteProblem("outValid while run is low");

    haltHoldCheck: assert property (@(posedge Clock) disable iff (rst) halted |=> halted)
        else noteProblem("halted dropped without reset");

    haltQuietCheck: assert property (@(posedge Clock) disable iff (rst) halted |-> !outValid)
        else noteProblem("outValid after halt");

    resetHaltCheck: assert property (@(posedge Clock) $fell(rst) |-> !halted)
        else noteProblem("halted still high after reset");

    ackStartCheck: assert property (@(posedge Clock) disable iff (rst)
        (wbCyc && wbStb && !wbAck) |=> wbAck)
        else noteProblem("ack did not follow stb by one cycle");

    ackLengthCheck: assert property (@(posedge Clock) disable iff (rst) wbAck |=> !wbAck)
        else noteProblem("ack longer than one cycle");

    ackCauseCheck: assert property (@(posedge Clock) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb))
        else noteProblem("ack without cyc and stb");

    readDataCheck: assert property (@(posedge Clock) disable iff (rst)
        (wbAck && $past(!wbWe)) |-> wbReadData == readExpected)
        else noteMismatch("read data", readExpected, wbReadData);

    function automatic logic [DataWidth-1:0] signExtend(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic logic [DataWidth-1:0] encode(input opcodeType op, input int ra,
                                                    input int rb, input logic [18:0] c);
        return {5'(op), ra[3:0], rb[3:0], c};
    endfunction

    task automatic applyReset();
        @(negedge Clock);
        rst = 1'b1;
        run = 1'b0;
        repeat (3) @(negedge Clock);
        rst = 1'b0;
    endtask

    task automatic wbTransfer(input logic write, input logic [AddrWidth-1:0] adr,
                              input logic [DataWidth-1:0] data);
        int waited;
        @(negedge Clock);
        if (write) begin
            memModel[adr] = data;
        end else begin
            readExpected = memModel[adr];
        end
        wbCyc       = 1'b1;
        wbStb       = 1'b1;
        wbWe        = write;
        wbAdr       = adr;
        wbWriteData = data;
        waited      = 0;
        while (!wbAck && waited < AckTimeout) begin
            @(negedge Clock);
            waited++;
        end
        if (!wbAck) noteProblem("no Wishbone ack before the timeout");
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic beginProgram();
        progLength    = 0;
        expectedCount = 0;
        instrSinceOut = 0;
        for (int i = 0; i < RegCount; i++) modelRegs[i] = '0;
    endtask

    // Assemble one instruction and advance the model
    task automatic addInstr(input opcodeType op, input int ra, input int rb,
                            input logic [18:0] c);
        progWords[progLength] = encode(op, ra, rb, c);
        progLength++;
        instrSinceOut++;
        case (op)
            opAddi: modelRegs[ra] = modelRegs[rb] + signExtend(c);
            opAndi: modelRegs[ra] = modelRegs[rb] & signExtend(c);
            opOri:  modelRegs[ra] = modelRegs[rb] | signExtend(c);
            opOut: begin
                expectedOut[expectedCount] = modelRegs[ra];
                expectedGap[expectedCount] = (expectedCount == 0) ? 0 : 6 * instrSinceOut;
                expectedCount++;
                instrSinceOut = 0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLength; i++) wbTransfer(1'b1, AddrWidth'(i), progWords[i]);
    endtask

    task automatic runUntilHalt(input int holdCycles);
        int waited;
        @(negedge Clock);
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < RunTimeout) begin
            @(negedge Clock);
            waited++;
        end
        if (!halted) noteProblem("CPU did not halt before the timeout");
        repeat (holdCycles) @(negedge Clock); // Watch for stray pulses after halt
        run = 1'b0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("test %s passed", currentTest);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", currentTest, errorCount - errorsAtStart);
        end
    endtask

    task automatic startTest(input string name);
        currentTest   = name;
        errorsAtStart = errorCount;
    endtask

    initial begin
        logic [AddrWidth-1:0] adrList [$];
        logic [AddrWidth-1:0] adr;
        opcodeType            op;

        rst            = 1'b1;
        run            = 1'b0;
        wbCyc          = 1'b0;
        wbStb          = 1'b0;
        wbWe           = 1'b0;
        wbAdr          = '0;
        wbWriteData    = '0;
        readExpected   = '0;
        errorCount     = 0;
        testsRun       = 0;
        testsFailed    = 0;
        cycleCount     = 0;
        lastPulseCycle = 0;
        pendingCycle   = 0;
        beginProgram();
        void'($urandom(58764));
        applyReset();

        startTest("wishboneRoundTrip");
        for (int i = 0; i < 16; i++) begin
            adr = AddrWidth'($urandom);
            adrList.push_back(adr);
            wbTransfer(1'b1, adr, $urandom);
        end
        foreach (adrList[i]) wbTransfer(1'b0, adrList[i], '0);
        finishTest();

        startTest("signExtension");
        applyReset();
        beginProgram();
        addInstr(opAddi, 1, 0, {1'b1, 18'($urandom)}); // Negative C
        addInstr(opOut, 1, 0, '0);
        addInstr(opHalt, 0, 0, '0);
        loadProgram();
        runUntilHalt(8);
        finishTest();

        startTest("logicChain");
        applyReset();
        beginProgram();
        addInstr(opAddi, 5, 5, 19'($urandom));
        addInstr(opOut, 5, 0, '0);
        addInstr(opAndi, 5, 5, 19'($urandom));
        addInstr(opOut, 5, 0, '0);
        addInstr(opOri, 5, 5, 19'($urandom));
        addInstr(opOut, 5, 0, '0);
        addInstr(opHalt, 0, 0, '0);
        loadProgram();
        runUntilHalt(8);
        finishTest();

        startTest("randomProgram");
        applyReset();
        beginProgram();
        for (int i = 0; i < 20; i++) begin
            case ($urandom % 3)
                0:       op = opAddi;
                1:       op = opAndi;
                default: op = opOri;
            endcase
            addInstr(op, $urandom % RegCount, $urandom % RegCount, 19'($urandom));
            if ($urandom % 2) addInstr(opOut, $urandom % RegCount, 0, '0);
        end
        addInstr(opOut, $urandom % RegCount, 0, '0);
        addInstr(opHalt, 0, 0, '0);
        loadProgram();
        runUntilHalt(8);
        finishTest();

        startTest("outputTiming");
        applyReset();
        beginProgram();
        addInstr(opOut, 0, 0, '0);
        addInstr(opAddi, 2, 0, 19'd7);
        addInstr(opAddi, 3, 2, 19'd9);
        addInstr(opOut, 3, 0, '0);
        addInstr(opOut, 2, 0, '0);
        addInstr(opHalt, 0, 0, '0);
        loadProgram();
        repeat (24) @(negedge Clock); // Idle with run low
        runUntilHalt(8);
        finishTest();

        startTest("haltAndRestart");
        applyReset();
        beginProgram();
        addInstr(opAddi, 4, 0, 19'($urandom));
        addInstr(opOut, 4, 0, '0);
        addInstr(opHalt, 0, 0, '0);
        loadProgram();
        wbTransfer(1'b1, AddrWidth'(progLength), encode(opOut, 4, 0, '0)); // Never reached
        runUntilHalt(30);
        applyReset();
        runUntilHalt(12); // Same program again from address 0
        finishTest();

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
source/cpuPkg.sv
source/generalRegister.sv
source/registerDecoder.sv
source/busMux.sv
source/arithmeticUnit.sv
source/specialRegisters.sv
source/programMemory.sv
source/controlUnit.sv
source/cpuTop.sv
testbench/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f project.f -Mdir obj_dir -o cpuSim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log
grep -q "^Test OK$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
